// ==== common/cpuDefs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and address width
`define DATA_W 16

// Register-select field width
`define REG_SEL_W 2

// Stack grows down from here
`define SP_RESET 16'h00FF

// Bit positions in the 4-bit flag register
`define FLAG_Z 0
`define FLAG_N 1
`define FLAG_C 2
`define FLAG_V 3

`endif

// ==== common/cpuPkg.sv ====
`default_nettype none
`include "cpuDefs.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        OP_ALU  = 4'd0, // Register op
        OP_IMM  = 4'd1, // Immediate op
        OP_JMP  = 4'd2, // Relative jump
        OP_FLG  = 4'd3, // Flag branch or set/clear
        OP_PUSH = 4'd4,
        OP_POP  = 4'd5,
        OP_ST   = 4'd6, // Store through A
        OP_LD   = 4'd7  // Load through A
    } opClassT;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SHL   = 4'd5,
        ALU_SHR   = 4'd6,
        ALU_PASSB = 4'd7
    } aluFuncT;

    typedef enum logic [`REG_SEL_W-1:0] {
        REG_A  = 2'd0,
        REG_B  = 2'd1,
        REG_C  = 2'd2,
        REG_SP = 2'd3
    } regSelT;

    // Memory address source
    typedef enum logic [1:0] {
        ADDR_PC = 2'd0,
        ADDR_SP = 2'd1,
        ADDR_A  = 2'd2
    } addrSelT;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_EXEC,
        ST_MEM,
        ST_MEM_WAIT,
        ST_STACK_ADJ,
        ST_HALT
    } cpuStateT;

endpackage

`default_nettype wire

// ==== common/ctrlIf.sv ====
`default_nettype none
`include "cpuDefs.svh"

interface ctrlIf import cpuPkg::*; ();
    aluFuncT            aluFunc;
    logic               aluSelB;   // 1 selects the immediate
    logic               regWrEn;
    regSelT             regWrSel;
    logic               flagWrEn;  // Flags from the ALU
    logic               flagSetEn; // Single flag set/clear
    logic               pcLoadInc;
    logic               pcLoadRel;
    logic               irLoad;
    logic               mdrLoad;
    addrSelT            addrSel;
    logic               spInc;
    logic               spDec;
    logic               wrFromMdr; // Write-back from memory data
    logic [`DATA_W-1:0] instr;

    modport controller (
        output aluFunc, aluSelB, regWrEn, regWrSel, flagWrEn, flagSetEn,
        output pcLoadInc, pcLoadRel, irLoad, mdrLoad, addrSel,
        output spInc, spDec, wrFromMdr
    );

    modport datapath (
        input  aluFunc, aluSelB, regWrEn, regWrSel, flagWrEn, flagSetEn,
        input  pcLoadInc, pcLoadRel, irLoad, mdrLoad, addrSel,
        input  spInc, spDec, wrFromMdr,
        output instr
    );
endinterface

`default_nettype wire

// ==== control/instrDecode.sv ====
`default_nettype none
`include "cpuDefs.svh"

module instrDecode
    import cpuPkg::*;
(
    input  logic [`DATA_W-1:0] instr,
    input  logic [3:0]         flags,
    output opClassT            opClass,
    output logic               isFlagOp,
    output logic               condTrue,
    output regSelT             dstSel,
    output regSelT             srcSel,
    output aluFuncT            aluFunc,
    output logic [`DATA_W-1:0] imm
);

    assign opClass = opClassT'(instr[15:12]);
    assign dstSel  = regSelT'(instr[11:10]);
    assign srcSel  = regSelT'(instr[9:8]);

    // Bit 11 picks set/clear over branch
    assign isFlagOp = (opClass == OP_FLG) && instr[11];
    assign condTrue = (opClass == OP_FLG) && !instr[11]
                      && (flags[instr[9:8]] == instr[10]);

    always_comb begin
        aluFunc = ALU_ADD;
        imm     = '0;
        case (opClass)
            OP_ALU: begin
                aluFunc = aluFuncT'(instr[7:4]);
            end
            OP_IMM: begin
                imm = {{(`DATA_W-8){1'b0}}, instr[7:0]}; // Zero-extended
                case (instr[9:8])
                    2'd0:    aluFunc = ALU_ADD;
                    2'd1:    aluFunc = ALU_SUB;
                    2'd2:    aluFunc = ALU_AND;
                    default: aluFunc = ALU_PASSB; // Load immediate
                endcase
            end
            OP_JMP: begin
                imm = {{(`DATA_W-12){instr[11]}}, instr[11:0]};
            end
            OP_FLG: begin
                imm = {{(`DATA_W-8){instr[7]}}, instr[7:0]}; // Branch offset
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== control/cpuControl.sv ====
`default_nettype none

module cpuControl
    import cpuPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    ctrlIf.controller    ctrl,
    input  opClassT      opClass,
    input  aluFuncT      decFunc,  // Function from the decoder
    input  regSelT       dstSel,
    input  logic         condTrue,
    input  logic         isFlagOp,
    output logic         memReq,
    output logic         memWe,
    input  logic         memAck,
    output logic         halted
);

    cpuStateT state;
    cpuStateT nextState;
    logic     accDone;
    logic     isWrite;
    logic     isStackOp;

    assign accDone   = memReq && memAck; // Ack seen on our own request
    assign isWrite   = (opClass == OP_PUSH) || (opClass == OP_ST);
    assign isStackOp = (opClass == OP_PUSH) || (opClass == OP_POP);
    assign halted    = (state == ST_HALT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_FETCH;
            memReq <= 1'b0;
            memWe  <= 1'b0;
        end else begin
            state  <= nextState;
            memReq <= (nextState == ST_FETCH) || (nextState == ST_MEM);
            memWe  <= (nextState == ST_MEM) && isWrite;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            ST_FETCH:      if (accDone) nextState = ST_FETCH_WAIT;
            ST_FETCH_WAIT: if (!memAck) nextState = ST_EXEC;
            ST_EXEC: begin
                case (opClass)
                    OP_ALU, OP_IMM, OP_JMP, OP_FLG:  nextState = ST_FETCH;
                    OP_PUSH, OP_POP, OP_ST, OP_LD:   nextState = ST_MEM;
                    default:                         nextState = ST_HALT; // Invalid class
                endcase
            end
            ST_MEM:        if (accDone) nextState = ST_MEM_WAIT;
            ST_MEM_WAIT: begin
                if (!memAck) begin
                    nextState = (opClass == OP_PUSH) ? ST_STACK_ADJ : ST_FETCH;
                end
            end
            ST_STACK_ADJ:  nextState = ST_FETCH;
            ST_HALT:       nextState = ST_HALT;
            default:       nextState = ST_HALT;
        endcase
    end

    always_comb begin
        ctrl.aluFunc   = ALU_PASSB;
        ctrl.aluSelB   = 1'b0;
        ctrl.regWrEn   = 1'b0;
        ctrl.regWrSel  = dstSel;
        ctrl.flagWrEn  = 1'b0;
        ctrl.flagSetEn = 1'b0;
        ctrl.pcLoadInc = 1'b0;
        ctrl.pcLoadRel = 1'b0;
        ctrl.irLoad    = 1'b0;
        ctrl.mdrLoad   = 1'b0;
        ctrl.addrSel   = ADDR_PC;
        ctrl.spInc     = 1'b0;
        ctrl.spDec     = 1'b0;
        ctrl.wrFromMdr = 1'b0;
        case (state)
            ST_FETCH: begin
                ctrl.irLoad    = accDone; // Capture word and step PC together
                ctrl.pcLoadInc = accDone;
            end
            ST_EXEC: begin
                case (opClass)
                    OP_ALU, OP_IMM: begin
                        ctrl.aluFunc  = decFunc;
                        ctrl.aluSelB  = (opClass == OP_IMM);
                        ctrl.regWrEn  = 1'b1;
                        ctrl.flagWrEn = 1'b1;
                    end
                    OP_JMP:  ctrl.pcLoadRel = 1'b1;
                    OP_FLG: begin
                        ctrl.flagSetEn = isFlagOp;
                        ctrl.pcLoadRel = condTrue;
                    end
                    OP_POP:  ctrl.spInc = 1'b1; // SP moves before the read
                    default: begin
                    end
                endcase
            end
            ST_MEM: begin
                ctrl.addrSel = isStackOp ? ADDR_SP : ADDR_A;
                ctrl.mdrLoad = accDone && !isWrite;
            end
            ST_MEM_WAIT: begin
                ctrl.addrSel = isStackOp ? ADDR_SP : ADDR_A;
                if (!memAck && !isWrite) begin
                    ctrl.regWrEn   = 1'b1; // Pop or load write-back
                    ctrl.wrFromMdr = 1'b1;
                end
            end
            ST_STACK_ADJ: ctrl.spDec = 1'b1; // After the push write
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== datapath/cpuDatapath.sv ====
`default_nettype none
`include "cpuDefs.svh"

module cpuDatapath
    import cpuPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    ctrlIf.datapath            ctrl,
    input  regSelT             dstSel,
    input  regSelT             srcSel,
    input  logic [`DATA_W-1:0] imm,
    input  logic [`DATA_W-1:0] aluY,
    input  logic [3:0]         aluFlags,
    output logic [`DATA_W-1:0] aluA,
    output logic [`DATA_W-1:0] aluB,
    output logic [3:0]         flags,
    output logic [`DATA_W-1:0] memAddr,
    output logic [`DATA_W-1:0] memWdata,
    input  logic [`DATA_W-1:0] memRdata
);

    logic [`DATA_W-1:0] regA;
    logic [`DATA_W-1:0] regB;
    logic [`DATA_W-1:0] regC;
    logic [`DATA_W-1:0] sp;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] ir;
    logic [`DATA_W-1:0] mdr;
    logic [`DATA_W-1:0] regView [4];
    logic [`DATA_W-1:0] dstVal;
    logic [`DATA_W-1:0] srcVal;
    logic [`DATA_W-1:0] wrData;

    // Register file as seen by the select fields
    assign regView[REG_A]  = regA;
    assign regView[REG_B]  = regB;
    assign regView[REG_C]  = regC;
    assign regView[REG_SP] = sp;

    assign dstVal = regView[dstSel];
    assign srcVal = regView[srcSel];
    assign wrData = ctrl.wrFromMdr ? mdr : aluY;

    assign aluA       = dstVal; // Destination doubles as operand A
    assign aluB       = ctrl.aluSelB ? imm : srcVal;
    assign memWdata   = dstVal;
    assign ctrl.instr = ir;

    always_comb begin
        case (ctrl.addrSel)
            ADDR_SP: memAddr = sp;
            ADDR_A:  memAddr = regA;
            default: memAddr = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= '0;
            sp    <= `SP_RESET;
            flags <= '0;
        end else begin
            if (ctrl.pcLoadInc) begin
                pc <= pc + 1'b1;
            end else if (ctrl.pcLoadRel) begin
                pc <= pc + imm; // PC already points past the instruction
            end

            if (ctrl.regWrEn && ctrl.regWrSel == REG_SP) begin
                sp <= wrData;
            end else if (ctrl.spInc) begin
                sp <= sp + 1'b1;
            end else if (ctrl.spDec) begin
                sp <= sp - 1'b1;
            end

            if (ctrl.flagWrEn) begin
                flags <= aluFlags;
            end else if (ctrl.flagSetEn) begin
                flags[ir[9:8]] <= ir[10]; // Flag number and new value
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irLoad) ir <= memRdata;
        if (ctrl.mdrLoad) mdr <= memRdata;
        if (ctrl.regWrEn) begin
            case (ctrl.regWrSel)
                REG_A:   regA <= wrData;
                REG_B:   regB <= wrData;
                REG_C:   regC <= wrData;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/cpuAlu.sv ====
`default_nettype none
`include "cpuDefs.svh"

module cpuAlu
    import cpuPkg::*;
(
    input  aluFuncT            func,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] y,
    output logic [3:0]         flagsOut
);

    logic [`DATA_W:0] wide; // Result with carry-out bit
    logic             carry;
    logic             ovf;

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (func)
            ALU_ADD: begin
                wide  = {1'b0, a} + {1'b0, b};
                carry = wide[`DATA_W];
                ovf   = (a[`DATA_W-1] == b[`DATA_W-1])
                        && (wide[`DATA_W-1] != a[`DATA_W-1]);
            end
            ALU_SUB: begin
                wide  = {1'b0, a} - {1'b0, b};
                carry = wide[`DATA_W]; // Borrow
                ovf   = (a[`DATA_W-1] != b[`DATA_W-1])
                        && (wide[`DATA_W-1] != a[`DATA_W-1]);
            end
            ALU_AND:   wide = {1'b0, a & b};
            ALU_OR:    wide = {1'b0, a | b};
            ALU_XOR:   wide = {1'b0, a ^ b};
            ALU_SHL:   wide = {1'b0, a << b[3:0]};
            ALU_SHR:   wide = {1'b0, a >> b[3:0]};
            ALU_PASSB: wide = {1'b0, b};
            default:   wide = '0;
        endcase
    end

    assign y = wide[`DATA_W-1:0];

    assign flagsOut[`FLAG_Z] = (y == '0);
    assign flagsOut[`FLAG_N] = y[`DATA_W-1];
    assign flagsOut[`FLAG_C] = carry;
    assign flagsOut[`FLAG_V] = ovf;

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
`default_nettype none
`include "cpuDefs.svh"

module cpuTop
    import cpuPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    output logic               memReq,
    output logic               memWe,
    output logic [`DATA_W-1:0] memAddr,
    output logic [`DATA_W-1:0] memWdata,
    input  logic [`DATA_W-1:0] memRdata,
    input  logic               memAck,
    output logic               halted
);

    ctrlIf ctrlBus ();

    opClassT            opClass;
    aluFuncT            decFunc;
    regSelT             dstSel;
    regSelT             srcSel;
    logic               isFlagOp;
    logic               condTrue;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] aluA;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] aluY;
    logic [3:0]         aluFlags;
    logic [3:0]         flags;

    cpuControl control_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrlBus.controller),
        .opClass  (opClass),
        .decFunc  (decFunc),
        .dstSel   (dstSel),
        .condTrue (condTrue),
        .isFlagOp (isFlagOp),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAck   (memAck),
        .halted   (halted)
    );

    instrDecode decode_i (
        .instr    (ctrlBus.instr),
        .flags    (flags),
        .opClass  (opClass),
        .isFlagOp (isFlagOp),
        .condTrue (condTrue),
        .dstSel   (dstSel),
        .srcSel   (srcSel),
        .aluFunc  (decFunc),
        .imm      (imm)
    );

    cpuDatapath datapath_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrlBus.datapath),
        .dstSel   (dstSel),
        .srcSel   (srcSel),
        .imm      (imm),
        .aluY     (aluY),
        .aluFlags (aluFlags),
        .aluA     (aluA),
        .aluB     (aluB),
        .flags    (flags),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

    cpuAlu alu_i (
        .func     (ctrlBus.aluFunc),
        .a        (aluA),
        .b        (aluB),
        .y        (aluY),
        .flagsOut (aluFlags)
    );

endmodule

`default_nettype wire

// ==== sim/cpuChecker.sv ====
`default_nettype none
`include "cpuDefs.svh"

module cpuChecker (
    input  logic               clk,
    input  logic               rst,
    input  logic               memReq,
    input  logic               memWe,
    input  logic               memAck,
    input  logic [`DATA_W-1:0] memAddr,
    input  logic [`DATA_W-1:0] memWdata,
    input  logic               halted
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_EXP = 64;

    logic [`DATA_W-1:0] expAddr [MAX_EXP];
    logic [`DATA_W-1:0] expData [MAX_EXP];
    int   expCount   = 0;
    int   nextIdx    = 0;
    int   checked    = 0;
    int   mismatches = 0;
    int   missing    = 0;
    int   extra      = 0;
    int   otherErrs  = 0;
    int   errors     = 0; // Sum of all of the above
    logic ackPrev    = 1'b0;
    logic haltSeen   = 1'b0;

    // Called by the testbench top while it reads the trace
    task automatic expectWrite(input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] d);
        if (expCount < MAX_EXP) begin
            expAddr[expCount] = a;
            expData[expCount] = d;
            expCount++;
        end else begin
            $display("The trace holds more than %0d expected writes", MAX_EXP);
            otherErrs++;
            errors++;
        end
    endtask

    task automatic checkWrite();
        checked++;
        if (nextIdx >= expCount) begin
            $display("Unexpected write of %h to address %h after the last expected write",
                     memWdata, memAddr);
            extra++;
            errors++;
        end else begin
            if (memAddr !== expAddr[nextIdx]) begin
                $display("MISMATCH memAddr: expected %h, got %h (write %0d)",
                         expAddr[nextIdx], memAddr, nextIdx);
                mismatches++;
                errors++;
            end
            if (memWdata !== expData[nextIdx]) begin
                $display("MISMATCH memWdata: expected %h, got %h (write %0d)",
                         expData[nextIdx], memWdata, nextIdx);
                mismatches++;
                errors++;
            end
            nextIdx++;
        end
    endtask

    // Expected writes that never happened
    task automatic countMissing();
        missing = expCount - nextIdx;
        if (missing > 0) begin
            $display("%0d expected writes never happened", missing);
            errors = errors + missing;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ackPrev  <= 1'b0;
            haltSeen <= 1'b0;
        end else begin
            ackPrev <= memAck;
            if (memAck && !ackPrev && memReq && memWe) begin // Write accepted
                checkWrite();
            end
            if (halted && memReq) begin
                $display("The CPU raised a memory request while halted");
                otherErrs++;
                errors++;
            end
            if (haltSeen && !halted) begin
                $display("halted dropped without a reset");
                otherErrs++;
                errors++;
            end
            if (halted) haltSeen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sim/cpuTb.sv ====
`default_nettype none
`include "cpuDefs.svh"

module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               rst;
    logic               memReq;
    logic               memWe;
    logic               memAck;
    logic               halted;
    logic [`DATA_W-1:0] memAddr;
    logic [`DATA_W-1:0] memWdata;
    logic [`DATA_W-1:0] memRdata;

    logic [`DATA_W-1:0] mem [256]; // Indexed by the low address byte
    integer seed;
    int     ackWait;
    logic   busy;        // Request seen, ack pending
    int     cycles      = 0;
    int     cycleLimit  = 0;
    int     progWords   = 0;
    int     setupErrors = 0;
    int     timeouts    = 0;
    int     totalErrors;

    cpuTop dut_i (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .memAck   (memAck),
        .halted   (halted)
    );

    cpuChecker checker_i (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAck   (memAck),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // Four-phase memory with a random ack delay of 1 to 4 cycles
    always @(posedge clk) begin
        if (rst) begin
            memAck  <= #1 1'b0;
            busy    <= 1'b0;
            ackWait <= 0;
        end else if (memAck) begin
            if (!memReq) memAck <= #1 1'b0;
        end else if (busy) begin
            if (ackWait == 0) begin
                memAck <= #1 1'b1;
                busy   <= 1'b0;
                if (memWe) begin
                    mem[memAddr[7:0]] <= memWdata;
                end else begin
                    memRdata <= #1 mem[memAddr[7:0]];
                end
            end else begin
                ackWait <= ackWait - 1;
            end
        end else if (memReq) begin
            busy    <= 1'b1;
            ackWait <= $random(seed) & 3;
        end
    end

    task automatic skipLine(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != -1 && c != "\n") c = $fgetc(fd);
    endtask

    // P lines preload memory, W lines go to the checker in order
    task automatic loadTrace();
        int                 fd;
        int                 c;
        int                 n;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] d;
        fd = $fopen("sim/cpuTrace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file sim/cpuTrace.txt");
            setupErrors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "P" || c == "W") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) begin
                    $display("Malformed line in the trace file");
                    setupErrors++;
                end else if (c == "P") begin
                    mem[a[7:0]] = d;
                    progWords++;
                end else begin
                    checker_i.expectWrite(a, d);
                end
                skipLine(fd);
            end else if (c == "#") begin
                skipLine(fd);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    initial begin
        seed     = 8458;
        rst      = 1'b1;
        memAck   = 1'b0;
        memRdata = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hF5, 8'(i)}; // Invalid class, so a runaway PC halts
        end
        loadTrace();
        cycleLimit = 40 * progWords + 200;

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        while (!halted && cycles < cycleLimit) @(posedge clk);
        if (!halted) begin
            $display("Timeout: the CPU did not halt within %0d cycles", cycleLimit);
            timeouts = 1;
        end else begin
            while (cycles < cycleLimit) @(posedge clk); // Any write after halt counts as extra
        end
        @(negedge clk);

        checker_i.countMissing();
        totalErrors = checker_i.errors + setupErrors + timeouts;
        $display("Summary: %0d writes checked, %0d mismatched, %0d missing, %0d extra, %0d other",
                 checker_i.checked, checker_i.mismatches, checker_i.missing,
                 checker_i.extra, checker_i.otherErrs + setupErrors + timeouts);
        if (totalErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/cpuTrace.txt ====
# P <addr> <word>: preload memory word (hex), text after # is the mnemonic
# W <addr> <data>: next expected memory write (hex), in order
P 00 1735 # ldi b,35
P 01 1B0C # ldi c,0c
P 02 0600 # add b,c
P 03 1380 # ldi a,80
P 04 6400 # st b
P 05 0910 # sub c,b
P 06 1381 # ldi a,81
P 07 6800 # st c
P 08 0940 # xor c,b
P 09 1382 # ldi a,82
P 0A 6800 # st c
P 0B 0630 # or b,c
P 0C 163C # andi b,3c
P 0D 1B03 # ldi c,03
P 0E 0650 # shl b,c
P 0F 1383 # ldi a,83
P 10 6400 # st b
P 11 0660 # shr b,c
P 12 1384 # ldi a,84
P 13 6400 # st b
P 14 1508 # subi b,08 gives zero
P 15 3402 # branch if Z=1 to 18
P 16 1387 # wrong path
P 17 6000 # wrong path
P 18 175A # ldi b,5a
P 19 1386 # ldi a,86
P 1A 6400 # st b
P 1B 1B00 # ldi c,00
P 1C 1901 # subi c,01
P 1D 1801 # addi c,01 sets carry
P 1E 3204 # branch if C=0 to 23, not taken
P 1F 17C0 # ldi b,c0
P 20 1388 # ldi a,88
P 21 6400 # st b
P 22 2001 # jmp to 24
P 23 6000 # wrong path
P 24 3F00 # set V
P 25 3702 # branch if V=1 to 28
P 26 138A # wrong path
P 27 6000 # wrong path
P 28 3B00 # clear V
P 29 3302 # branch if V=0 to 2c
P 2A 138B # wrong path
P 2B 6000 # wrong path
P 2C 17F1 # ldi b,f1
P 2D 138C # ldi a,8c
P 2E 6400 # st b
P 2F 1B77 # ldi c,77
P 30 4000 # push a
P 31 4400 # push b
P 32 4800 # push c
P 33 5000 # pop a
P 34 5800 # pop c
P 35 5400 # pop b
P 36 6000 # st a
P 37 138D # ldi a,8d
P 38 6800 # st c
P 39 138E # ldi a,8e
P 3A 6400 # st b
P 3B 13A0 # ldi a,a0
P 3C 7400 # ld b
P 3D 1411 # addi b,11
P 3E 6400 # st b
P 3F F000 # invalid, halts
P 40 6400 # must never run
P A0 1234 # data word for the load
W 0080 0041
W 0081 FFCB
W 0082 FF8A
W 0083 0040
W 0084 0008
W 0086 005A
W 0088 00C0
W 008C 00F1
W 00FF 008C
W 00FE 00F1
W 00FD 0077
W 0077 0077
W 008D 00F1
W 008E 008C
W 00A0 1245

// ==== compile.f ====
+incdir+common
common/cpuPkg.sv
common/ctrlIf.sv
control/instrDecode.sv
control/cpuControl.sv
datapath/cpuDatapath.sv
design/cpuAlu.sv
design/cpuTop.sv
sim/cpuChecker.sv
sim/cpuTb.sv
